/* Bender.yml */
package:
  name: ui_render

sources:
  - include_dirs:
      - include
    files:
      - hw/color_pkg.sv
      - hw/board_pkg.sv
      - hw/move_decoder.sv
      - hw/player_controller.sv
      - hw/background_renderer.sv
      - hw/sprite_renderer.sv
      - hw/ui_render.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_ui_render.sv

/* hw/background_renderer.sv */
// ======================================================================
// background layer: two sky bands, grass strip and checkered dirt
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "ui_render_macros.svh"

module background_renderer
    import color_pkg::*;
    import board_pkg::*;
(
    input  coord_t x,
    input  coord_t y,
    output rgb_t   bg_color,
    output logic   bg_en
);

    coord_t     dirt_dy;
    logic [3:0] dirt_code;

    // 2x2 pixel cells, four cells per pattern period
    assign dirt_dy   = y - coord_t'(`UI_DIRT_Y);
    assign dirt_code = {x[2:1], dirt_dy[2:1]};

    always_comb begin
        bg_en    = 1'b1;
        bg_color = rgb_t'(`UI_BLACK);
        if (y < coord_t'(`UI_GRASS_Y)) begin
            if (y < coord_t'(`UI_SKY_SPLIT_Y)) begin
                bg_color = rgb_t'(`UI_SKY_LIGHT);
            end else begin
                bg_color = rgb_t'(`UI_SKY);
            end
        end else if (y < coord_t'(`UI_DIRT_Y)) begin
            // bright line on the top grass row
            if (y == coord_t'(`UI_GRASS_Y)) begin
                bg_color = rgb_t'(`UI_GRASS_BRIGHT);
            end else begin
                bg_color = rgb_t'(`UI_GRASS_GREEN);
            end
        end else if (y < coord_t'(`UI_DIRT_END_Y)) begin
            case (dirt_code)
                4'b0000, 4'b0101, 4'b1010, 4'b1111: bg_color = rgb_t'(`UI_DIRT_DARK);
                4'b0001, 4'b0100, 4'b1001, 4'b1100: bg_color = rgb_t'(`UI_DIRT_MID);
                4'b0010, 4'b0111, 4'b1000, 4'b1101: bg_color = rgb_t'(`UI_DIRT_LIGHT);
                default:                            bg_color = rgb_t'(`UI_DIRT_GRAY);
            endcase
        end else begin
            // nothing drawn below the dirt
            bg_en = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/board_pkg.sv */
// ======================================================================
// board types: screen coordinate, tile index, move command and the
// motion state of the player
// ======================================================================
`default_nettype none

package board_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [3:0] tile_t;

    // move command, one to three tile steps
    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_STEP1 = 2'd1,
        CMD_STEP2 = 2'd2,
        CMD_STEP3 = 2'd3
    } move_cmd_t;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_MOVING  = 2'd1,
        ST_JUMPING = 2'd2
    } motion_state_t;

endpackage

`default_nettype wire

/* hw/color_pkg.sv */
// ======================================================================
// pixel colour type shared by the renderers and the compositor
// ======================================================================
`default_nettype none

package color_pkg;

    // one pixel, 8 bits per channel
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

endpackage

`default_nettype wire

/* hw/move_decoder.sv */
// ======================================================================
// move button decoder: rising edge detect on three level buttons and
// priority encode into a single move command
// ======================================================================
`timescale 1ns/1ps
`default_nettype none

module move_decoder
    import board_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      move_1,
    input  logic      move_2,
    input  logic      move_3,
    output move_cmd_t cmd
);

    logic [2:0] btn_prev;
    logic [2:0] btn_rise;

    // previous button levels
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_prev <= 3'b000;
        end else begin
            btn_prev <= {move_3, move_2, move_1};
        end
    end

    assign btn_rise = {move_3, move_2, move_1} & ~btn_prev;

    // move_1 wins over move_2, move_2 over move_3
    always_comb begin
        if (btn_rise[0]) begin
            cmd = CMD_STEP1;
        end else if (btn_rise[1]) begin
            cmd = CMD_STEP2;
        end else if (btn_rise[2]) begin
            cmd = CMD_STEP3;
        end else begin
            cmd = CMD_NONE;
        end
    end

endmodule

`default_nettype wire

/* hw/player_controller.sv */
// ======================================================================
// player motion FSM: idle, slide and jump per tile step, with the
// sprite position, current tile and busy flag
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "ui_render_macros.svh"

module player_controller
    import board_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  move_cmd_t cmd,
    output coord_t    player_x,
    output coord_t    player_y,
    output tile_t     current_tile,
    output logic      is_moving
);

    motion_state_t state;
    logic [4:0]    cnt;
    // steps still to run after the current one
    logic [1:0]    steps_left;
    tile_t         target_tile;
    coord_t        slide_x;

    logic          start_ok;
    logic [1:0]    cmd_extra;
    logic          last_move;
    logic          last_jump;
    logic          more_steps;
    coord_t        jump_off;

    // jump arc: up by 4 per cycle, peak at cycle 8, then down by 4
    function automatic coord_t jump_height(input logic [3:0] c);
        coord_t h;
        if (c < 4'd8) begin
            h = coord_t'(c) << 2;
        end else if (c == 4'd8) begin
            h = coord_t'(`UI_JUMP_PEAK);
        end else begin
            h = coord_t'(5'd16 - c) << 2;
        end
        return h;
    endfunction

    // opcode to number of follow-up steps
    always_comb begin
        case (cmd)
            CMD_STEP2: cmd_extra = 2'd1;
            CMD_STEP3: cmd_extra = 2'd2;
            default:   cmd_extra = 2'd0;
        endcase
    end

    assign start_ok   = (state == ST_IDLE) && (cmd != CMD_NONE) &&
                        (current_tile < tile_t'(`UI_LAST_TILE));
    assign last_move  = (cnt == 5'(`UI_MOVE_CYCLES - 1));
    assign last_jump  = (cnt == 5'(`UI_JUMP_CYCLES - 1));
    assign more_steps = (steps_left != 2'd0) && (current_tile < tile_t'(`UI_LAST_TILE));

    // ==================================================================
    // motion state machine
    // ==================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            cnt          <= 5'd0;
            steps_left   <= 2'd0;
            target_tile  <= '0;
            current_tile <= '0;
            slide_x      <= coord_t'(`UI_PLAYER_OFFSET);
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_ok) begin
                        state       <= ST_MOVING;
                        cnt         <= 5'd0;
                        steps_left  <= cmd_extra;
                        target_tile <= current_tile + tile_t'(1);
                    end
                end
                ST_MOVING: begin
                    // slide lands exactly on the next tile after the last cycle
                    slide_x <= slide_x + coord_t'(`UI_STEP_PX);
                    if (last_move) begin
                        cnt          <= 5'd0;
                        current_tile <= target_tile;
                        state        <= ST_JUMPING;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                ST_JUMPING: begin
                    if (last_jump) begin
                        cnt <= 5'd0;
                        if (more_steps) begin
                            state       <= ST_MOVING;
                            steps_left  <= steps_left - 2'd1;
                            target_tile <= current_tile + tile_t'(1);
                        end else begin
                            state <= ST_IDLE;
                        end
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // sprite position
    assign jump_off  = (state == ST_JUMPING) ? jump_height(cnt[3:0]) : '0;
    assign player_x  = slide_x;
    assign player_y  = coord_t'(`UI_BASE_Y) - jump_off;
    assign is_moving = (state != ST_IDLE);

endmodule

`default_nettype wire

/* hw/sprite_renderer.sv */
// ======================================================================
// player chip sprite: 16x16 box with side pins and a red marker
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "ui_render_macros.svh"

module sprite_renderer
    import color_pkg::*;
    import board_pkg::*;
(
    input  coord_t x,
    input  coord_t y,
    input  coord_t player_x,
    input  coord_t player_y,
    output rgb_t   spr_color,
    output logic   spr_en
);

    logic [10:0] x_end;
    logic [10:0] y_end;
    logic        in_box;
    coord_t      dx;
    coord_t      dy;
    logic [3:0]  sx;
    logic [3:0]  sy;

    // one bit wider so the box end never wraps
    assign x_end  = {1'b0, player_x} + 11'(`UI_SPRITE_SIZE);
    assign y_end  = {1'b0, player_y} + 11'(`UI_SPRITE_SIZE);
    assign in_box = (x >= player_x) && ({1'b0, x} < x_end) &&
                    (y >= player_y) && ({1'b0, y} < y_end);

    // sprite-local column and row
    assign dx = x - player_x;
    assign dy = y - player_y;
    assign sx = dx[3:0];
    assign sy = dy[3:0];

    always_comb begin
        spr_en    = 1'b0;
        spr_color = rgb_t'(`UI_BLACK);
        if (in_box) begin
            case (sy)
                // top and bottom edges
                4'd0, 4'd15: begin
                    if (sx >= 4'd2 && sx <= 4'd13) begin
                        spr_en    = 1'b1;
                        spr_color = rgb_t'(`UI_CHIP_GRAY);
                    end
                end
                // pin rows, every column covered
                4'd4, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9, 4'd10, 4'd11: begin
                    spr_en = 1'b1;
                    if (sx <= 4'd1 || sx >= 4'd14) begin
                        spr_color = rgb_t'(`UI_CHIP_SILVER);
                    end else if (sx == 4'd2 || sx == 4'd13) begin
                        spr_color = rgb_t'(`UI_CHIP_GRAY);
                    end else begin
                        spr_color = rgb_t'(`UI_CHIP_BLACK);
                    end
                end
                // rows 1-3 and 12-14, marker on rows 2 and 3
                default: begin
                    if (sx == 4'd1 || sx == 4'd14) begin
                        spr_en    = 1'b1;
                        spr_color = rgb_t'(`UI_CHIP_GRAY);
                    end else if (sx >= 4'd2 && sx <= 4'd13) begin
                        spr_en = 1'b1;
                        if ((sy == 4'd2 || sy == 4'd3) && (sx == 4'd6 || sx == 4'd7)) begin
                            spr_color = rgb_t'(`UI_CHIP_RED);
                        end else begin
                            spr_color = rgb_t'(`UI_CHIP_BLACK);
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/ui_render.sv */
// ======================================================================
// pixel renderer top: move decode, player motion, background and
// sprite layers, priority mix and registered colour output
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "ui_render_macros.svh"

module ui_render
    import color_pkg::*;
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  coord_t     x,
    input  coord_t     y,
    input  logic       move_1,
    input  logic       move_2,
    input  logic       move_3,
    output logic [7:0] r,
    output logic [7:0] g,
    output logic [7:0] b,
    output tile_t      current_tile,
    output logic       is_moving
);

    move_cmd_t cmd;
    coord_t    player_x;
    coord_t    player_y;
    rgb_t      bg_color;
    logic      bg_en;
    rgb_t      spr_color;
    logic      spr_en;
    rgb_t      pix;

    move_decoder u_decoder (
        .clk    (clk),
        .rst    (rst),
        .move_1 (move_1),
        .move_2 (move_2),
        .move_3 (move_3),
        .cmd    (cmd)
    );

    player_controller u_controller (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd),
        .player_x     (player_x),
        .player_y     (player_y),
        .current_tile (current_tile),
        .is_moving    (is_moving)
    );

    background_renderer u_background (
        .x        (x),
        .y        (y),
        .bg_color (bg_color),
        .bg_en    (bg_en)
    );

    sprite_renderer u_sprite (
        .x         (x),
        .y         (y),
        .player_x  (player_x),
        .player_y  (player_y),
        .spr_color (spr_color),
        .spr_en    (spr_en)
    );

    // sprite over background over black
    assign pix = spr_en ? spr_color : (bg_en ? bg_color : rgb_t'(`UI_BLACK));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            r <= 8'd0;
            g <= 8'd0;
            b <= 8'd0;
        end else begin
            r <= pix.r;
            g <= pix.g;
            b <= pix.b;
        end
    end

endmodule

`default_nettype wire

/* include/ui_render_macros.svh */
// ======================================================================
// screen bands, board geometry, motion timing and palette values
// for the board game pixel renderer
// ======================================================================
`ifndef UI_RENDER_MACROS_SVH
`define UI_RENDER_MACROS_SVH

// vertical bands of the background
`define UI_SKY_SPLIT_Y   70
`define UI_GRASS_Y       140
`define UI_DIRT_Y        150
`define UI_DIRT_END_Y    180

// board geometry
`define UI_TILE_SIZE     48
`define UI_PLAYER_OFFSET 16
`define UI_BASE_Y        124
`define UI_LAST_TILE     9

// one step is a slide then a jump
`define UI_MOVE_CYCLES   24
`define UI_JUMP_CYCLES   16
// slide advance per cycle, tile size over move cycles
`define UI_STEP_PX       2

// player chip
`define UI_SPRITE_SIZE   16
`define UI_JUMP_PEAK     30

// palette, 24-bit rgb
`define UI_SKY_LIGHT     24'h87CEEB
`define UI_SKY           24'h5DADE2
`define UI_GRASS_BRIGHT  24'h7FC83F
`define UI_GRASS_GREEN   24'h55A02F
`define UI_DIRT_DARK     24'h6B4A2F
`define UI_DIRT_MID      24'h8B653F
`define UI_DIRT_LIGHT    24'hA07A50
`define UI_DIRT_GRAY     24'h707070
`define UI_CHIP_BLACK    24'h202020
`define UI_CHIP_GRAY     24'h505050
`define UI_CHIP_SILVER   24'hC0C0C0
`define UI_CHIP_RED      24'hFF0000
`define UI_BLACK         24'h000000

`endif

/* sim/tb_ui_render.sv */
// ======================================================================
// random testbench for the pixel renderer with a reference model of
// the move decoder, player motion, background and chip sprite
// ======================================================================
`timescale 1ns/1ps
`default_nettype none
`include "ui_render_macros.svh"

module tb_ui_render
    import color_pkg::*;
    import board_pkg::*;
();

    logic clk;
    logic rst;
    coord_t x;
    coord_t y;
    logic move_1;
    logic move_2;
    logic move_3;
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
    tile_t current_tile;
    logic is_moving;

    // reference model state
    motion_state_t m_state;
    int m_cnt;
    int m_left;
    tile_t m_tile;
    logic [2:0] m_prev;
    rgb_t exp_pix;

    // inputs as driven for the next edge
    coord_t cur_x;
    coord_t cur_y;
    logic [2:0] cur_btn;
    logic cur_rst;
    logic seen_busy;

    ui_render dut (
        .clk          (clk),
        .rst          (rst),
        .x            (x),
        .y            (y),
        .move_1       (move_1),
        .move_2       (move_2),
        .move_3       (move_3),
        .r            (r),
        .g            (g),
        .b            (b),
        .current_tile (current_tile),
        .is_moving    (is_moving)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // ==================================================================
    // error reporting and compare tasks
    // ==================================================================
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_pixel(input rgb_t exp, input rgb_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL t=%0t {r,g,b} expected %06h got %06h", $time, exp, act));
        end
    endtask

    task automatic check_tile(input tile_t exp, input tile_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL t=%0t current_tile expected %0d got %0d", $time, exp, act));
        end
    endtask

    task automatic check_busy(input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL t=%0t is_moving expected %b got %b", $time, exp, act));
        end
    endtask

    task automatic check_cycles(input int exp, input int act);
        if (act != exp) begin
            abort_run($sformatf("FAIL t=%0t is_moving cycles expected %0d got %0d",
                                $time, exp, act));
        end
    endtask

    // ==================================================================
    // reference model
    // ==================================================================
    function automatic int jump_lift(input int c);
        if (c < 8) begin
            return 4 * c;
        end else if (c == 8) begin
            return `UI_JUMP_PEAK;
        end
        return 64 - 4 * c;
    endfunction

    function automatic int model_px();
        int base;
        base = int'(m_tile) * `UI_TILE_SIZE + `UI_PLAYER_OFFSET;
        if (m_state == ST_MOVING) begin
            return base + `UI_STEP_PX * m_cnt;
        end
        return base;
    endfunction

    function automatic int model_py();
        if (m_state == ST_JUMPING) begin
            return `UI_BASE_Y - jump_lift(m_cnt);
        end
        return `UI_BASE_Y;
    endfunction

    // 4x4 checker with a two bit shade per column from dark 0 to gray 3
    function automatic rgb_t dirt_color(input int col, input int row);
        logic [7:0] shades;
        logic [1:0] pick;
        case (row)
            0:       shades = 8'b01_10_01_00;
            1:       shades = 8'b10_01_00_01;
            2:       shades = 8'b11_00_11_10;
            default: shades = 8'b00_11_10_11;
        endcase
        pick = shades[2 * col +: 2];
        case (pick)
            2'd0:    return rgb_t'(`UI_DIRT_DARK);
            2'd1:    return rgb_t'(`UI_DIRT_MID);
            2'd2:    return rgb_t'(`UI_DIRT_LIGHT);
            default: return rgb_t'(`UI_DIRT_GRAY);
        endcase
    endfunction

    function automatic rgb_t bg_pixel(input int px, input int py);
        if (py < `UI_SKY_SPLIT_Y) begin
            return rgb_t'(`UI_SKY_LIGHT);
        end else if (py < `UI_GRASS_Y) begin
            return rgb_t'(`UI_SKY);
        end else if (py == `UI_GRASS_Y) begin
            return rgb_t'(`UI_GRASS_BRIGHT);
        end else if (py < `UI_DIRT_Y) begin
            return rgb_t'(`UI_GRASS_GREEN);
        end else if (py < `UI_DIRT_END_Y) begin
            return dirt_color((px / 2) % 4, ((py - `UI_DIRT_Y) / 2) % 4);
        end
        return rgb_t'(`UI_BLACK);
    endfunction

    function automatic rgb_t sprite_pixel(input int sx, input int sy, output logic en);
        en = 1'b1;
        if (sy == 0 || sy == 15) begin
            en = (sx >= 2 && sx <= 13);
            return rgb_t'(`UI_CHIP_GRAY);
        end else if (sy >= 4 && sy <= 11) begin
            if (sx <= 1 || sx >= 14) begin
                return rgb_t'(`UI_CHIP_SILVER);
            end else if (sx == 2 || sx == 13) begin
                return rgb_t'(`UI_CHIP_GRAY);
            end
            return rgb_t'(`UI_CHIP_BLACK);
        end
        if (sx == 1 || sx == 14) begin
            return rgb_t'(`UI_CHIP_GRAY);
        end else if ((sy == 2 || sy == 3) && (sx == 6 || sx == 7)) begin
            return rgb_t'(`UI_CHIP_RED);
        end
        en = (sx >= 2 && sx <= 13);
        return rgb_t'(`UI_CHIP_BLACK);
    endfunction

    function automatic rgb_t model_pixel(input int px, input int py);
        int sx;
        int sy;
        logic en;
        rgb_t c;
        sx = px - model_px();
        sy = py - model_py();
        if (sx >= 0 && sx < `UI_SPRITE_SIZE && sy >= 0 && sy < `UI_SPRITE_SIZE) begin
            c = sprite_pixel(sx, sy, en);
            if (en) begin
                return c;
            end
        end
        return bg_pixel(px, py);
    endfunction

    task automatic model_reset();
        m_state = ST_IDLE;
        m_cnt = 0;
        m_left = 0;
        m_tile = '0;
        m_prev = 3'b000;
    endtask

    task automatic model_step(input logic [2:0] btn);
        logic [2:0] rise;
        int k;
        rise = btn & ~m_prev;
        m_prev = btn;
        k = 0;
        if (rise[0]) begin
            k = 1;
        end else if (rise[1]) begin
            k = 2;
        end else if (rise[2]) begin
            k = 3;
        end
        case (m_state)
            ST_IDLE: begin
                if (k != 0 && m_tile < `UI_LAST_TILE) begin
                    m_state = ST_MOVING;
                    m_cnt = 0;
                    m_left = k - 1;
                end
            end
            ST_MOVING: begin
                if (m_cnt == `UI_MOVE_CYCLES - 1) begin
                    m_cnt = 0;
                    m_tile = m_tile + tile_t'(1);
                    m_state = ST_JUMPING;
                end else begin
                    m_cnt++;
                end
            end
            default: begin
                if (m_cnt == `UI_JUMP_CYCLES - 1) begin
                    m_cnt = 0;
                    if (m_left > 0 && m_tile < `UI_LAST_TILE) begin
                        m_state = ST_MOVING;
                        m_left--;
                    end else begin
                        m_state = ST_IDLE;
                    end
                end else begin
                    m_cnt++;
                end
            end
        endcase
    endtask

    // one clock that checks the last edge, advances the model and drives inputs
    task automatic tick(input int nx, input int ny, input logic [2:0] nbtn, input logic nrst);
        @(posedge clk);
        check_pixel(exp_pix, rgb_t'({r, g, b}));
        check_tile(m_tile, current_tile);
        check_busy(m_state != ST_IDLE, is_moving);
        seen_busy = is_moving;
        if (cur_rst) begin
            exp_pix = rgb_t'(`UI_BLACK);
            model_reset();
        end else begin
            exp_pix = model_pixel(cur_x, cur_y);
            model_step(cur_btn);
        end
        rst <= nrst;
        x <= coord_t'(nx);
        y <= coord_t'(ny);
        {move_3, move_2, move_1} <= nbtn;
        cur_rst = nrst;
        cur_x = coord_t'(nx);
        cur_y = coord_t'(ny);
        cur_btn = nbtn;
    endtask

    // pixel drawn around the sprite box
    function automatic int near_x();
        return model_px() - 4 + int'($urandom % 24);
    endfunction

    function automatic int near_y();
        return model_py() - 4 + int'($urandom % 24);
    endfunction

    // ==================================================================
    // stimulus
    // ==================================================================
    initial begin
        int k;
        int tile0;
        int steps;
        int busy;
        int waited;
        int px0;
        int py0;
        logic [2:0] press;
        logic [2:0] noise;
        void'($urandom(32'he5543058));
        rst = 1'b1;
        x = '0;
        y = '0;
        move_1 = 1'b0;
        move_2 = 1'b0;
        move_3 = 1'b0;
        cur_rst = 1'b1;
        cur_x = '0;
        cur_y = '0;
        cur_btn = 3'b000;
        seen_busy = 1'b0;
        exp_pix = rgb_t'(`UI_BLACK);
        model_reset();

        // reset held over the first two edges with zero outputs after each
        @(posedge clk);
        tick(0, 0, 3'b000, 1'b0);
        tick(0, 0, 3'b000, 1'b0);

        // background anywhere on screen including below the dirt
        repeat (400) begin
            tick(int'($urandom % 640), int'($urandom % 240), 3'b000, 1'b0);
        end

        // full scan of the sprite box with a two pixel margin
        px0 = model_px();
        py0 = model_py();
        for (int sy = -2; sy < `UI_SPRITE_SIZE + 2; sy++) begin
            for (int sx = -2; sx < `UI_SPRITE_SIZE + 2; sx++) begin
                tick(px0 + sx, py0 + sy, 3'b000, 1'b0);
            end
        end

        // random moves until the last tile
        while (m_tile < `UI_LAST_TILE) begin
            if ($urandom % 4 == 0) begin
                press = 3'($urandom % 7 + 1);
            end else begin
                press = 3'b001 << ($urandom % 3);
            end
            k = press[0] ? 1 : (press[1] ? 2 : 3);
            tile0 = m_tile;
            steps = (k < `UI_LAST_TILE - tile0) ? k : `UI_LAST_TILE - tile0;
            tick(near_x(), near_y(), press, 1'b0);
            tick(near_x(), near_y(), 3'b000, 1'b0);
            busy = 0;
            for (waited = 0; waited < 200 && (busy == 0 || seen_busy); waited++) begin
                // short presses while sliding must be ignored
                noise = 3'b000;
                if (cur_btn == 3'b000 && m_state == ST_MOVING && $urandom % 8 == 0) begin
                    noise = 3'b001 << ($urandom % 3);
                end
                tick(near_x(), near_y(), noise, 1'b0);
                if (seen_busy) begin
                    busy++;
                end
            end
            if (seen_busy) begin
                abort_run("player motion never finished within 200 cycles");
            end
            check_cycles(40 * steps, busy);
            check_tile(tile_t'(tile0 + steps), current_tile);
        end

        // at the last tile every button does nothing
        for (int i = 0; i < 3; i++) begin
            tick(near_x(), near_y(), 3'b001 << i, 1'b0);
            repeat (6) begin
                tick(near_x(), near_y(), 3'b000, 1'b0);
            end
        end
        check_tile(tile_t'(`UI_LAST_TILE), current_tile);
        check_busy(1'b0, is_moving);
        tick(0, 0, 3'b000, 1'b0);

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* ui_render.f */
+incdir+include
hw/color_pkg.sv
hw/board_pkg.sv
hw/move_decoder.sv
hw/player_controller.sv
hw/background_renderer.sv
hw/sprite_renderer.sv
hw/ui_render.sv
sim/tb_ui_render.sv
